/* Bender.yml */
package:
  name: compute_tile

sources:
  - tile_pkg.sv
  - wb_bus.sv
  - mem_port_adapter.sv
  - wb_sram.sv
  - boot_rom.sv
  - compute_tile.sv
  - target: test
    files:
      - tb_compute_tile.sv

/* boot_rom.sv */
`timescale 1ns/1ps

module boot_rom (
   input  logic            clk,
   input  logic            rst_i,
   input  logic            rom_stb_i,
   input  tile_pkg::addr_t rom_adr_i,
   output logic            rom_ack_o,
   output tile_pkg::data_t rom_dat_o
);

   import tile_pkg::*;

   rom_idx_t idx;

   assign idx = rom_adr_i[4:2];         // Wraps every 32 bytes

   // Table lookup, registered
   always_ff @(posedge clk) begin
      rom_dat_o <= ROM_TABLE[idx];
   end

   // Writes get acked too, table never changes
   always_ff @(posedge clk) begin
      if (rst_i) begin
         rom_ack_o <= 1'b0;
      end else begin
         rom_ack_o <= rom_stb_i & ~rom_ack_o; // Single ack per strobe
      end
   end

endmodule

/* compute_tile.f */
tile_pkg.sv
wb_bus.sv
mem_port_adapter.sv
wb_sram.sv
boot_rom.sv
compute_tile.sv
tb_compute_tile.sv

/* compute_tile.sv */
`timescale 1ns/1ps

module compute_tile (
   input  logic                                    clk,
   input  logic                                    rst_i,
   // Bus masters
   input  logic [tile_pkg::MASTERS-1:0]            m_cyc_i,
   input  logic [tile_pkg::MASTERS-1:0]            m_stb_i,
   input  logic [tile_pkg::MASTERS-1:0]            m_we_i,
   input  tile_pkg::addr_t [tile_pkg::MASTERS-1:0] m_adr_i,
   input  tile_pkg::data_t [tile_pkg::MASTERS-1:0] m_dat_i,
   input  tile_pkg::sel_t  [tile_pkg::MASTERS-1:0] m_sel_i,
   output logic [tile_pkg::MASTERS-1:0]            m_ack_o,
   output logic [tile_pkg::MASTERS-1:0]            m_err_o,
   output tile_pkg::data_t [tile_pkg::MASTERS-1:0] m_dat_o,
   // Debug memory access
   input  logic                                    dbg_cyc_i,
   input  logic                                    dbg_stb_i,
   input  logic                                    dbg_we_i,
   input  tile_pkg::addr_t                         dbg_adr_i,
   input  tile_pkg::data_t                         dbg_dat_i,
   input  tile_pkg::sel_t                          dbg_sel_i,
   output logic                                    dbg_ack_o,
   output tile_pkg::data_t                         dbg_dat_o,
   // Snoop
   output logic                                    snoop_en_o,
   output tile_pkg::addr_t                         snoop_adr_o
);

   import tile_pkg::*;

   // Bus to memory adapter
   logic     s_mem_cyc;
   logic     s_mem_stb;
   logic     s_mem_we;
   addr_t    s_mem_adr;
   data_t    s_mem_dat_w;
   sel_t     s_mem_sel;
   logic     s_mem_ack;
   data_t    s_mem_dat_r;
   // Bus to boot ROM
   logic     s_rom_stb;
   addr_t    s_rom_adr;
   logic     s_rom_ack;
   data_t    s_rom_dat;
   // Adapter to SRAM
   logic     mem_stb;
   logic     mem_we;
   mem_idx_t mem_idx;
   data_t    mem_dat_w;
   sel_t     mem_sel;
   logic     mem_ack;
   data_t    mem_dat_r;

   wb_bus u_bus (
      .clk         (clk),
      .rst_i       (rst_i),
      .m_cyc_i     (m_cyc_i),
      .m_stb_i     (m_stb_i),
      .m_we_i      (m_we_i),
      .m_adr_i     (m_adr_i),
      .m_dat_i     (m_dat_i),
      .m_sel_i     (m_sel_i),
      .m_ack_o     (m_ack_o),
      .m_err_o     (m_err_o),
      .m_dat_o     (m_dat_o),
      .s_mem_cyc_o (s_mem_cyc),
      .s_mem_stb_o (s_mem_stb),
      .s_mem_we_o  (s_mem_we),
      .s_mem_adr_o (s_mem_adr),
      .s_mem_dat_o (s_mem_dat_w),
      .s_mem_sel_o (s_mem_sel),
      .s_mem_ack_i (s_mem_ack),
      .s_mem_dat_i (s_mem_dat_r),
      .s_rom_stb_o (s_rom_stb),
      .s_rom_adr_o (s_rom_adr),
      .s_rom_ack_i (s_rom_ack),
      .s_rom_dat_i (s_rom_dat),
      .snoop_en_o  (snoop_en_o),
      .snoop_adr_o (snoop_adr_o)
   );

   mem_port_adapter u_mem_adapter (
      .clk       (clk),
      .rst_i     (rst_i),
      .bus_cyc_i (s_mem_cyc),
      .bus_stb_i (s_mem_stb),
      .bus_we_i  (s_mem_we),
      .bus_adr_i (s_mem_adr),
      .bus_dat_i (s_mem_dat_w),
      .bus_sel_i (s_mem_sel),
      .bus_ack_o (s_mem_ack),
      .bus_dat_o (s_mem_dat_r),
      .dbg_cyc_i (dbg_cyc_i),
      .dbg_stb_i (dbg_stb_i),
      .dbg_we_i  (dbg_we_i),
      .dbg_adr_i (dbg_adr_i),
      .dbg_dat_i (dbg_dat_i),
      .dbg_sel_i (dbg_sel_i),
      .dbg_ack_o (dbg_ack_o),
      .dbg_dat_o (dbg_dat_o),
      .mem_stb_o (mem_stb),
      .mem_we_o  (mem_we),
      .mem_idx_o (mem_idx),
      .mem_dat_o (mem_dat_w),
      .mem_sel_o (mem_sel),
      .mem_ack_i (mem_ack),
      .mem_dat_i (mem_dat_r)
   );

   wb_sram u_ram (
      .clk       (clk),
      .rst_i     (rst_i),
      .mem_stb_i (mem_stb),
      .mem_we_i  (mem_we),
      .mem_idx_i (mem_idx),
      .mem_dat_i (mem_dat_w),
      .mem_sel_i (mem_sel),
      .mem_ack_o (mem_ack),
      .mem_dat_o (mem_dat_r)
   );

   boot_rom u_bootrom (
      .clk       (clk),
      .rst_i     (rst_i),
      .rom_stb_i (s_rom_stb),
      .rom_adr_i (s_rom_adr),
      .rom_ack_o (s_rom_ack),
      .rom_dat_o (s_rom_dat)
   );

endmodule

/* mem_port_adapter.sv */
`timescale 1ns/1ps

module mem_port_adapter (
   input  logic               clk,
   input  logic               rst_i,
   // From the bus
   input  logic               bus_cyc_i,
   input  logic               bus_stb_i,
   input  logic               bus_we_i,
   input  tile_pkg::addr_t    bus_adr_i,
   input  tile_pkg::data_t    bus_dat_i,
   input  tile_pkg::sel_t     bus_sel_i,
   output logic               bus_ack_o,
   output tile_pkg::data_t    bus_dat_o,
   // Debug memory access
   input  logic               dbg_cyc_i,
   input  logic               dbg_stb_i,
   input  logic               dbg_we_i,
   input  tile_pkg::addr_t    dbg_adr_i,
   input  tile_pkg::data_t    dbg_dat_i,
   input  tile_pkg::sel_t     dbg_sel_i,
   output logic               dbg_ack_o,
   output tile_pkg::data_t    dbg_dat_o,
   // Towards the SRAM
   output logic               mem_stb_o,
   output logic               mem_we_o,
   output tile_pkg::mem_idx_t mem_idx_o,
   output tile_pkg::data_t    mem_dat_o,
   output tile_pkg::sel_t     mem_sel_o,
   input  logic               mem_ack_i,
   input  tile_pkg::data_t    mem_dat_i
);

   import tile_pkg::*;

   logic  bus_req;
   logic  dbg_req;
   logic  own_vld;                      // Port is taken
   logic  own_dbg;                      // Owner is debug, else bus
   addr_t own_adr;

   assign bus_req = bus_cyc_i & bus_stb_i;
   assign dbg_req = dbg_cyc_i & dbg_stb_i;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         own_vld <= 1'b0;
         own_dbg <= 1'b0;
      end else if (!own_vld) begin
         own_vld <= dbg_req | bus_req;
         own_dbg <= dbg_req;            // Debug wins a tie
      end else if (mem_ack_i) begin
         own_vld <= 1'b0;               // Free after the owner's ack
      end
   end

   // Forward the owner's request
   assign mem_stb_o = own_vld & (own_dbg ? dbg_req : bus_req);
   assign mem_we_o  = own_dbg ? dbg_we_i : bus_we_i;
   assign own_adr   = own_dbg ? dbg_adr_i : bus_adr_i;
   assign mem_idx_o = own_adr[11:2];    // Word index, wraps at 4 KiB
   assign mem_dat_o = own_dbg ? dbg_dat_i : bus_dat_i;
   assign mem_sel_o = own_dbg ? dbg_sel_i : bus_sel_i;

   // Ack to the owner only, waiting side sees nothing
   assign bus_ack_o = own_vld & ~own_dbg & mem_ack_i;
   assign dbg_ack_o = own_vld & own_dbg & mem_ack_i;
   assign bus_dat_o = mem_dat_i;
   assign dbg_dat_o = mem_dat_i;

endmodule

/* tb_compute_tile.sv */
`timescale 1ns/1ps

module tb_compute_tile;

   import tile_pkg::*;

   localparam int TIMEOUT = 200;        // Cycles per wait
   localparam int JOBS    = 12;         // Accesses per master in the mixed run

   logic                    clk;
   logic                    rst_i;
   logic [MASTERS-1:0]      m_cyc_i;
   logic [MASTERS-1:0]      m_stb_i;
   logic [MASTERS-1:0]      m_we_i;
   addr_t [MASTERS-1:0]     m_adr_i;
   data_t [MASTERS-1:0]     m_dat_i;
   sel_t  [MASTERS-1:0]     m_sel_i;
   logic [MASTERS-1:0]      m_ack_o;
   logic [MASTERS-1:0]      m_err_o;
   data_t [MASTERS-1:0]     m_dat_o;
   logic                    dbg_cyc_i;
   logic                    dbg_stb_i;
   logic                    dbg_we_i;
   addr_t                   dbg_adr_i;
   data_t                   dbg_dat_i;
   sel_t                    dbg_sel_i;
   logic                    dbg_ack_o;
   data_t                   dbg_dat_o;
   logic                    snoop_en_o;
   addr_t                   snoop_adr_o;

   logic [31:0]        rng_state = 32'h3026_6248;
   data_t              model [0:MEM_WORDS-1]; // Expected SRAM contents
   logic [MASTERS-1:0] pending;         // Access open per master
   logic [MASTERS-1:0] exp_err;
   logic [MASTERS-1:0] exp_we;
   logic [MASTERS-1:0] exp_mem;         // Targets the SRAM region
   data_t              exp_dat [MASTERS];
   addr_t              exp_adr [MASTERS];
   logic               dbg_pending;
   logic               dbg_exp_we;
   data_t              dbg_exp_dat;
   addr_t              job_adr [MASTERS][JOBS];
   logic               job_we  [MASTERS][JOBS];
   data_t              job_dat [MASTERS][JOBS];
   sel_t               job_sel [MASTERS][JOBS];

   compute_tile u_dut (.*);

   always #4 clk = ~clk;                // 8 ns period

   task automatic report_mismatch(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic abort_on_timeout(input string what);
      $display("Timeout, %s", what);
      $display("tests failed");
      $fatal(1);
   endtask

   function automatic logic [31:0] xorshift();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input sel_t s);
      data_t w;
      w = old_w;
      for (int b = 0; b < 4; b++) begin
         if (s[b]) w[8*b +: 8] = new_w[8*b +: 8]; // Only selected lanes land
      end
      return w;
   endfunction

   // Err bit above the read data, memory writes also update the model
   function automatic logic [32:0] ref_access(input logic we, input addr_t a, input data_t d,
                                              input sel_t s);
      logic [32:0] res;
      if (!a[31]) begin
         if (we) model[a[11:2]] = merge_bytes(model[a[11:2]], d, s); // Aliased at 4 KiB
         res = {1'b0, model[a[11:2]]};
      end else if (a[31:28] == ROM_NIBBLE) begin
         res = {1'b0, ROM_TABLE[a[4:2]]}; // Writes leave the table alone
      end else begin
         res = {1'b1, 32'h0};            // NA region and holes answer err
      end
      return res;
   endfunction

   task automatic bus_access(input int m, input logic we, input addr_t a, input data_t d,
                             input sel_t s);
      logic [32:0] res;
      logic        done;
      @(negedge clk);
      res        = ref_access(we, a, d, s);
      exp_err[m] = res[32];
      exp_dat[m] = res[31:0];
      exp_we[m]  = we;
      exp_mem[m] = !a[31];
      exp_adr[m] = a;
      pending[m] = 1'b1;
      m_cyc_i[m] = 1'b1;
      m_stb_i[m] = 1'b1;
      m_we_i[m]  = we;
      m_adr_i[m] = a;
      m_dat_i[m] = d;
      m_sel_i[m] = s;
      done = 1'b0;
      for (int n = 0; n < TIMEOUT && !done; n++) begin
         @(posedge clk);
         done = m_ack_o[m] | m_err_o[m];
      end
      assert (done) else
         abort_on_timeout($sformatf("master %0d got no ack or err for address %h", m, a));
      @(negedge clk);
      m_cyc_i[m] = 1'b0;
      m_stb_i[m] = 1'b0;
   endtask

   task automatic dbg_access(input logic we, input addr_t a, input data_t d, input sel_t s);
      logic [32:0] res;
      logic        done;
      @(negedge clk);
      res         = ref_access(we, a, d, s);
      dbg_exp_dat = res[31:0];
      dbg_exp_we  = we;
      dbg_pending = 1'b1;
      dbg_cyc_i = 1'b1;
      dbg_stb_i = 1'b1;
      dbg_we_i  = we;
      dbg_adr_i = a;
      dbg_dat_i = d;
      dbg_sel_i = s;
      done = 1'b0;
      for (int n = 0; n < TIMEOUT && !done; n++) begin
         @(posedge clk);
         done = dbg_ack_o;
      end
      assert (done) else
         abort_on_timeout($sformatf("debug port got no ack for address %h", a));
      @(negedge clk);
      dbg_cyc_i = 1'b0;
      dbg_stb_i = 1'b0;
   endtask

   task automatic run_jobs(input int m);
      for (int j = 0; j < JOBS; j++) begin
         bus_access(m, job_we[m][j], job_adr[m][j], job_dat[m][j], job_sel[m][j]);
      end
   endtask

   // Compare every response and the snoop port each cycle
   always @(posedge clk) begin
      logic  snp_exp;
      addr_t snp_adr;
      snp_exp = 1'b0;
      snp_adr = '0;
      if (!rst_i) begin
         for (int m = 0; m < MASTERS; m++) begin
            if (m_ack_o[m] || m_err_o[m]) begin
               assert (pending[m]) else
                  report_mismatch($sformatf("master %0d answered with no access open", m));
               assert (m_err_o[m] == exp_err[m] && m_ack_o[m] == !exp_err[m]) else
                  report_mismatch($sformatf("master %0d ack %b err %b, err expected %b",
                                            m, m_ack_o[m], m_err_o[m], exp_err[m]));
               if (!exp_we[m] && !exp_err[m]) begin
                  assert (m_dat_o[m] == exp_dat[m]) else
                     report_mismatch($sformatf("master %0d read %h at %h, expected %h",
                                               m, m_dat_o[m], exp_adr[m], exp_dat[m]));
               end
               if (exp_we[m] && exp_mem[m]) begin
                  snp_exp = 1'b1;        // Only memory writes are snooped
                  snp_adr = exp_adr[m];
               end
               pending[m] = 1'b0;
            end
         end
         if (dbg_ack_o) begin
            assert (dbg_pending) else
               report_mismatch("debug port acked with no access open");
            if (!dbg_exp_we) begin
               assert (dbg_dat_o == dbg_exp_dat) else
                  report_mismatch($sformatf("debug read %h, expected %h", dbg_dat_o, dbg_exp_dat));
            end
            dbg_pending = 1'b0;
         end
         assert (snoop_en_o == snp_exp) else
            report_mismatch($sformatf("snoop_en_o is %b, expected %b", snoop_en_o, snp_exp));
         if (snp_exp) begin
            assert (snoop_adr_o == snp_adr) else
               report_mismatch($sformatf("snoop_adr_o %h, expected %h", snoop_adr_o, snp_adr));
         end
      end
   end

   initial begin
      logic [31:0] r;
      addr_t       wadr [8];
      addr_t       dadr [8];
      clk = 1'b0;
      rst_i = 1'b1;
      m_cyc_i = '0;
      m_stb_i = '0;
      m_we_i = '0;
      m_adr_i = '0;
      m_dat_i = '0;
      m_sel_i = '0;
      dbg_cyc_i = 1'b0;
      dbg_stb_i = 1'b0;
      dbg_we_i = 1'b0;
      dbg_adr_i = '0;
      dbg_dat_i = '0;
      dbg_sel_i = '0;
      pending = '0;
      exp_err = '0;
      exp_we = '0;
      exp_mem = '0;
      dbg_pending = 1'b0;
      dbg_exp_we = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) model[i] = '0; // SRAM powers up cleared
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_i = 1'b0;
      @(negedge clk);
      assert (m_ack_o == '0 && m_err_o == '0 && !dbg_ack_o && !snoop_en_o) else
         report_mismatch("responses not low after reset");

      // Memory writes with random selects read back direct and aliased
      for (int i = 0; i < 8; i++) begin
         r = xorshift();
         wadr[i] = {1'b0, r[30:2], 2'b00};
         r = xorshift();
         bus_access(0, 1'b1, wadr[i], xorshift(), r[3:0]);
      end
      for (int i = 0; i < 8; i++) bus_access(0, 1'b0, wadr[i], '0, 4'hF);
      for (int i = 0; i < 8; i++) bus_access(0, 1'b0, wadr[i] ^ 32'h0001_5000, '0, 4'hF);

      // Boot ROM reads and an ignored write
      for (int i = 0; i < ROM_WORDS; i++) bus_access(1, 1'b0, 32'hF000_0000 + 4 * i, '0, 4'hF);
      bus_access(2, 1'b1, 32'hFFFF_FF04, xorshift(), 4'hF);
      bus_access(2, 1'b0, 32'hFFFF_FF04, '0, 4'hF);

      // NA region errs while memory still answers afterwards
      bus_access(1, 1'b0, 32'hE000_0010, '0, 4'hF);
      bus_access(1, 1'b1, 32'hE123_4568, xorshift(), 4'hF);
      bus_access(1, 0, wadr[0], '0, 4'hF);

      // All masters at once in separate word lanes
      for (int m = 0; m < MASTERS; m++) begin
         for (int j = 0; j < JOBS; j++) begin
            r = xorshift();
            job_adr[m][j] = {1'b0, r[30:4], master_idx_t'(m), 2'b00};
            job_we[m][j]  = r[0] | (j < 4); // Writes first and a mix after
            job_dat[m][j] = xorshift();
            job_sel[m][j] = r[7:4];
         end
      end
      fork
         run_jobs(0);
         run_jobs(1);
         run_jobs(2);
      join

      // Debug port against bus master 0 and reads across
      for (int j = 0; j < JOBS; j++) job_we[0][j] = 1'b1;
      for (int i = 0; i < 8; i++) begin
         r = xorshift();
         dadr[i] = {1'b0, r[30:4], 2'b11, 2'b00}; // Lane unused by the bus masters
      end
      fork
         run_jobs(0);
         for (int i = 0; i < 8; i++) dbg_access(1'b1, dadr[i], xorshift(), 4'hF);
      join
      for (int i = 0; i < 8; i++) bus_access(0, 1'b0, dadr[i], '0, 4'hF);
      for (int j = 0; j < JOBS; j++) dbg_access(1'b0, job_adr[0][j], '0, 4'hF);
      fork
         for (int i = 0; i < 8; i++) bus_access(1, 1'b0, dadr[i], '0, 4'hF);
         for (int j = 0; j < 8; j++) dbg_access(1'b0, job_adr[0][j], '0, 4'hF);
      join

      repeat (4) @(negedge clk);
      $display("all tests passed");
      $finish;
   end

endmodule

/* tile_pkg.sv */
package tile_pkg;

   // Bus word and address shapes
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [3:0]  sel_t;

   // Masters on the shared bus: instruction, data, NA master
   localparam int MASTERS = 3;
   typedef logic [1:0] master_idx_t;

   // Decoded slave regions
   localparam int SLAVES = 3;
   typedef enum logic [1:0] {
      REGION_MEM = 2'd0,                // Local SRAM, bit 31 clear
      REGION_NA  = 2'd1,                // Network adapter, answers err
      REGION_ROM = 2'd2                 // Boot ROM
   } region_t;

   localparam logic [3:0] NA_NIBBLE  = 4'hE;
   localparam logic [3:0] ROM_NIBBLE = 4'hF;

   // Local memory, 4 KiB of words, aliased above that
   localparam int MEM_WORDS = 1024;
   typedef logic [9:0] mem_idx_t;       // Address bits 11:2

   // Boot ROM
   localparam int ROM_WORDS = 8;
   typedef logic [2:0] rom_idx_t;       // Address bits 4:2

   // Small boot stub, sets up a stack and jumps into SRAM
   localparam data_t ROM_TABLE [0:ROM_WORDS-1] = '{
      32'h1800_0000,                    // l.movhi r0,0
      32'hA820_0000,                    // l.ori   r1,r0,0
      32'h1860_0000,                    // l.movhi r3,0
      32'hA863_0FFC,                    // l.ori   r3,r3,0xffc, stack top
      32'hA823_0000,                    // l.ori   r1,r3,0
      32'h0400_0003,                    // l.jal   to main
      32'h1500_0000,                    // l.nop, delay slot
      32'h0000_0000                     // l.j 0, park
   };

endpackage

/* wb_bus.sv */
`timescale 1ns/1ps

module wb_bus (
   input  logic                                    clk,
   input  logic                                    rst_i,
   // Masters
   input  logic [tile_pkg::MASTERS-1:0]            m_cyc_i,
   input  logic [tile_pkg::MASTERS-1:0]            m_stb_i,
   input  logic [tile_pkg::MASTERS-1:0]            m_we_i,
   input  tile_pkg::addr_t [tile_pkg::MASTERS-1:0] m_adr_i,
   input  tile_pkg::data_t [tile_pkg::MASTERS-1:0] m_dat_i,
   input  tile_pkg::sel_t  [tile_pkg::MASTERS-1:0] m_sel_i,
   output logic [tile_pkg::MASTERS-1:0]            m_ack_o,
   output logic [tile_pkg::MASTERS-1:0]            m_err_o,
   output tile_pkg::data_t [tile_pkg::MASTERS-1:0] m_dat_o,
   // Memory slave
   output logic                                    s_mem_cyc_o,
   output logic                                    s_mem_stb_o,
   output logic                                    s_mem_we_o,
   output tile_pkg::addr_t                         s_mem_adr_o,
   output tile_pkg::data_t                         s_mem_dat_o,
   output tile_pkg::sel_t                          s_mem_sel_o,
   input  logic                                    s_mem_ack_i,
   input  tile_pkg::data_t                         s_mem_dat_i,
   // Boot ROM slave
   output logic                                    s_rom_stb_o,
   output tile_pkg::addr_t                         s_rom_adr_o,
   input  logic                                    s_rom_ack_i,
   input  tile_pkg::data_t                         s_rom_dat_i,
   // Snoop
   output logic                                    snoop_en_o,
   output tile_pkg::addr_t                         snoop_adr_o
);

   import tile_pkg::*;

   logic [MASTERS-1:0] req;             // Pending requests
   logic               busy;            // Grant active
   master_idx_t        gnt_idx;         // Granted master, doubles as RR pointer
   master_idx_t        next_idx;        // Winner of next arbitration
   logic               next_vld;        // Someone is asking
   region_t            region;          // Decode of granted address
   addr_t              gnt_adr;
   logic               gnt_stb;         // Granted strobe, qualified
   logic               gnt_we;
   logic [SLAVES-1:0]  slv_ack;         // Acks by region
   logic               ack;             // Selected slave acked
   logic               na_err;          // Err responder for NA region
   data_t              rd_dat;          // Read data of selected slave

   assign req = m_cyc_i & m_stb_i;

   // Round robin, search starts right after the last grant
   always_comb begin
      int cand;
      next_idx = gnt_idx;
      next_vld = 1'b0;
      for (int k = MASTERS; k >= 1; k--) begin
         cand = (int'(gnt_idx) + k) % MASTERS; // Lowest k wins, last grant goes last
         if (req[cand]) begin
            next_idx = master_idx_t'(cand);
            next_vld = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         busy    <= 1'b0;
         gnt_idx <= master_idx_t'(MASTERS - 1); // Master 0 first after reset
      end else if (!busy) begin
         busy    <= next_vld;
         gnt_idx <= next_idx;           // Unchanged when nobody asks
      end else if (ack || na_err) begin
         busy    <= 1'b0;               // Release the edge after the response
      end
   end

   assign gnt_adr = m_adr_i[gnt_idx];
   assign gnt_we  = m_we_i[gnt_idx];
   assign gnt_stb = busy & m_cyc_i[gnt_idx] & m_stb_i[gnt_idx];

   // Address map
   always_comb begin
      case (gnt_adr[31:28])
         NA_NIBBLE:  region = REGION_NA;
         ROM_NIBBLE: region = REGION_ROM;
         default:    region = gnt_adr[31] ? REGION_NA : REGION_MEM; // Holes 8..D err too
      endcase
   end

   // Strobe only the decoded slave
   assign s_mem_cyc_o = busy & (region == REGION_MEM);
   assign s_mem_stb_o = gnt_stb & (region == REGION_MEM);
   assign s_mem_we_o  = gnt_we;
   assign s_mem_adr_o = gnt_adr;
   assign s_mem_dat_o = m_dat_i[gnt_idx];
   assign s_mem_sel_o = m_sel_i[gnt_idx];

   assign s_rom_stb_o = gnt_stb & (region == REGION_ROM);
   assign s_rom_adr_o = gnt_adr;

   // Nothing behind the NA region, answer err one cycle after stb
   always_ff @(posedge clk) begin
      if (rst_i) begin
         na_err <= 1'b0;
      end else begin
         na_err <= gnt_stb & (region == REGION_NA) & ~na_err; // Single cycle pulse
      end
   end

   always_comb begin
      slv_ack             = '0;
      slv_ack[REGION_MEM] = s_mem_ack_i;
      slv_ack[REGION_ROM] = s_rom_ack_i;
   end

   assign ack    = busy & slv_ack[region];
   assign rd_dat = (region == REGION_ROM) ? s_rom_dat_i : s_mem_dat_i;

   // Response goes back to the granted master only
   always_comb begin
      for (int i = 0; i < MASTERS; i++) begin
         m_ack_o[i] = ack & (gnt_idx == i);
         m_err_o[i] = na_err & (gnt_idx == i);
         m_dat_o[i] = (busy && gnt_idx == i) ? rd_dat : '0;
      end
   end

   // Cache snoop on every acked memory write
   assign snoop_en_o  = ack & (region == REGION_MEM) & gnt_we;
   assign snoop_adr_o = gnt_adr;

endmodule

/* wb_sram.sv */
`timescale 1ns/1ps

module wb_sram (
   input  logic               clk,
   input  logic               rst_i,
   input  logic               mem_stb_i,
   input  logic               mem_we_i,
   input  tile_pkg::mem_idx_t mem_idx_i,
   input  tile_pkg::data_t    mem_dat_i,
   input  tile_pkg::sel_t     mem_sel_i,
   output logic               mem_ack_o,
   output tile_pkg::data_t    mem_dat_o
);

   import tile_pkg::*;

   data_t mem [0:MEM_WORDS-1];          // Word array
   logic  access;                       // New access this cycle

   // Power up cleared
   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   // Not again while stb is still up after an ack
   assign access = mem_stb_i & ~mem_ack_o;

   always_ff @(posedge clk) begin
      if (access && mem_we_i) begin
         for (int b = 0; b < $bits(sel_t); b++) begin
            if (mem_sel_i[b]) begin
               mem[mem_idx_i][8*b +: 8] <= mem_dat_i[8*b +: 8]; // Selected lanes only
            end
         end
      end
   end

   // Read data is the old word on a write
   always_ff @(posedge clk) begin
      mem_dat_o <= mem[mem_idx_i];
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         mem_ack_o <= 1'b0;
      end else begin
         mem_ack_o <= access;           // High one cycle and low at least one after
      end
   end

endmodule
